//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_lsu
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/l1d_cache.sv
`timescale 1ns/1ps

module l1d_cache #(
  parameter int l1d_index_bits = 4
) (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      fence,
  input  logic                                      ren,
  input  logic                                      wen,
  input  logic                                      mapped,
  input  logic                                      uncacheable,
  input  logic [lsu_pkg::xlen-l1d_index_bits-3:0]   lookup_tag,
  input  logic [l1d_index_bits-1:0]                 lookup_index,
  input  logic [lsu_pkg::xlen-1:0]                  bus_rdata,
  input  logic                                      bus_rvalid,
  output logic                                      bus_arvalid,
  output logic                                      hit,
  output logic [lsu_pkg::xlen-1:0]                  word
);

  localparam int lines    = 2 ** l1d_index_bits;
  localparam int tag_bits = lsu_pkg::xlen - l1d_index_bits - 2;

  // one word per line
  logic [lsu_pkg::xlen-1:0] data_q [lines];
  logic [tag_bits-1:0]      tag_q  [lines];
  logic [lines-1:0]         valid_q;

  // uncached read path
  logic [lsu_pkg::xlen-1:0] uc_word_q;
  logic                     uc_valid_q;

  logic line_match;
  logic cacheable;
  logic cached_hit;
  logic fill;
  logic uc_capture;
  logic store_hit;

  assign line_match = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
  assign cacheable  = mapped && !uncacheable;
  assign cached_hit = ren && cacheable && line_match;

  assign fill       = ren && bus_rvalid && cacheable && !fence;  // dropped under fence
  assign uc_capture = ren && bus_rvalid && uncacheable && !uc_valid_q;
  assign store_hit  = wen && line_match;

  // held high while a mapped load misses, low in the completing cycle
  assign bus_arvalid = ren && mapped && !cached_hit && !uc_valid_q;

  assign hit  = cached_hit || uc_valid_q;
  assign word = uncacheable ? uc_word_q : data_q[lookup_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      if (fence) begin
        valid_q <= '0;
      end
      if (fill) begin
        valid_q[lookup_index] <= 1'b1;
      end
      if (store_hit) begin
        valid_q[lookup_index] <= 1'b0;  // write-around, just drop the line
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      data_q[lookup_index] <= bus_rdata;
      tag_q[lookup_index]  <= lookup_tag;
    end
  end

  // one-cycle valid after an uncacheable return
  always_ff @(posedge clock) begin
    if (reset) begin
      uc_valid_q <= 1'b0;
    end else begin
      uc_valid_q <= uc_capture;
    end
  end

  always_ff @(posedge clock) begin
    if (uc_capture) begin
      uc_word_q <= bus_rdata;
    end
  end

endmodule

//--- hw/load_align.sv
`timescale 1ns/1ps

module load_align (
  input  logic [lsu_pkg::xlen-1:0]  word,
  input  logic [1:0]                offset,
  input  lsu_pkg::lsu_op_t          op,
  output logic [lsu_pkg::xlen-1:0]  rdata
);

  logic [lsu_pkg::xlen-1:0] shifted;

  // one byte lane per offset step
  always_comb begin
    case (offset)
      2'd0:    shifted = word;
      2'd1:    shifted = {8'h00, word[31:8]};
      2'd2:    shifted = {16'h0000, word[31:16]};
      default: shifted = {24'h00_0000, word[31:24]};
    endcase
  end

  // size mask and extension
  always_comb begin
    case (op)
      lsu_pkg::op_lb: begin
        rdata = {{24{shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::op_lbu: begin
        rdata = {24'h00_0000, shifted[7:0]};
      end
      lsu_pkg::op_lh: begin
        rdata = {{16{shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::op_lhu: begin
        rdata = {16'h0000, shifted[15:0]};
      end
      lsu_pkg::op_lw: begin
        rdata = shifted;
      end
      default: begin
        rdata = '0;  // stores return nothing
      end
    endcase
  end

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

  // data and address width of the core
  parameter int xlen = 32;

  // load/store operation from the execute stage
  typedef enum logic [3:0] {
    op_lb  = 4'h0,
    op_lbu = 4'h1,
    op_lh  = 4'h2,
    op_lhu = 4'h3,
    op_lw  = 4'h4,
    op_sb  = 4'h8,  // stores have bit 3 set
    op_sh  = 4'h9,
    op_sw  = 4'ha
  } lsu_op_t;

  // byte count of an access, encoded as a strobe
  parameter logic [7:0] strb_byte = 8'h01;
  parameter logic [7:0] strb_half = 8'h03;
  parameter logic [7:0] strb_word = 8'h0f;
  parameter logic [7:0] strb_none = 8'h00;

endpackage

//--- hw/lsu_request_decode.sv
`timescale 1ns/1ps

module lsu_request_decode #(
  parameter int l1d_index_bits = 4
) (
  input  logic [lsu_pkg::xlen-1:0]                  addr,
  input  lsu_pkg::lsu_op_t                          op,
  output logic                                      mapped,
  output logic                                      uncacheable,
  output logic [lsu_pkg::xlen-l1d_index_bits-3:0]   lookup_tag,
  output logic [l1d_index_bits-1:0]                 lookup_index,
  output logic [1:0]                                offset,
  output logic [7:0]                                rstrb,
  output logic [7:0]                                wstrb
);

  // address map checks
  assign mapped =
    mem_map_pkg::in_region(addr, mem_map_pkg::clint_base, mem_map_pkg::clint_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::sram_base, mem_map_pkg::sram_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::uart_base, mem_map_pkg::uart_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::flash_base, mem_map_pkg::flash_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::psram_base, mem_map_pkg::psram_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::sdram_base, mem_map_pkg::sdram_limit);

  assign uncacheable =
    mem_map_pkg::in_region(addr, mem_map_pkg::clint_base, mem_map_pkg::clint_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::plic_base, mem_map_pkg::plic_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::uart_base, mem_map_pkg::uart_limit) ||
    mem_map_pkg::in_region(addr, mem_map_pkg::sdram_io_base,
                           mem_map_pkg::sdram_io_limit);

  // tag | index | byte offset
  assign lookup_tag   = addr[lsu_pkg::xlen-1:l1d_index_bits+2];
  assign lookup_index = addr[l1d_index_bits+1:2];
  assign offset       = addr[1:0];

  // read strobe from load size
  always_comb begin
    case (op)
      lsu_pkg::op_lb,
      lsu_pkg::op_lbu: rstrb = lsu_pkg::strb_byte;
      lsu_pkg::op_lh,
      lsu_pkg::op_lhu: rstrb = lsu_pkg::strb_half;
      lsu_pkg::op_lw:  rstrb = lsu_pkg::strb_word;
      default:         rstrb = lsu_pkg::strb_none;
    endcase
  end

  // write strobe from store size, data goes out unshifted
  always_comb begin
    case (op)
      lsu_pkg::op_sb: wstrb = lsu_pkg::strb_byte;
      lsu_pkg::op_sh: wstrb = lsu_pkg::strb_half;
      lsu_pkg::op_sw: wstrb = lsu_pkg::strb_word;
      default:        wstrb = lsu_pkg::strb_none;
    endcase
  end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int l1d_index_bits = 4
) (
  input  logic                      clock,
  input  logic                      reset,

  // execute stage
  input  logic [lsu_pkg::xlen-1:0]  addr,
  input  lsu_pkg::lsu_op_t          op,
  input  logic                      ren,
  input  logic                      wen,
  input  logic [lsu_pkg::xlen-1:0]  wdata,
  input  logic                      fence,
  output logic [lsu_pkg::xlen-1:0]  rdata,
  output logic                      rvalid,
  output logic                      wready,

  // bus read
  output logic [lsu_pkg::xlen-1:0]  bus_araddr,
  output logic                      bus_arvalid,
  output logic [7:0]                bus_rstrb,
  input  logic [lsu_pkg::xlen-1:0]  bus_rdata,
  input  logic                      bus_rvalid,

  // bus write
  output logic [lsu_pkg::xlen-1:0]  bus_awaddr,
  output logic                      bus_awvalid,
  output logic [lsu_pkg::xlen-1:0]  bus_wdata,
  output logic [7:0]                bus_wstrb,
  output logic                      bus_wvalid,
  input  logic                      bus_wready
);

  logic [lsu_pkg::xlen-l1d_index_bits-3:0] lookup_tag;
  logic [l1d_index_bits-1:0]               lookup_index;
  logic [1:0]                              offset;
  logic                                    mapped;
  logic                                    uncacheable;
  logic                                    hit;
  logic [lsu_pkg::xlen-1:0]                word;

  lsu_request_decode #(
    .l1d_index_bits (l1d_index_bits)
  ) decode0 (
    .addr         (addr),
    .op           (op),
    .mapped       (mapped),
    .uncacheable  (uncacheable),
    .lookup_tag   (lookup_tag),
    .lookup_index (lookup_index),
    .offset       (offset),
    .rstrb        (bus_rstrb),
    .wstrb        (bus_wstrb)
  );

  l1d_cache #(
    .l1d_index_bits (l1d_index_bits)
  ) cache0 (
    .clock        (clock),
    .reset        (reset),
    .fence        (fence),
    .ren          (ren),
    .wen          (wen),
    .mapped       (mapped),
    .uncacheable  (uncacheable),
    .lookup_tag   (lookup_tag),
    .lookup_index (lookup_index),
    .bus_rdata    (bus_rdata),
    .bus_rvalid   (bus_rvalid),
    .bus_arvalid  (bus_arvalid),
    .hit          (hit),
    .word         (word)
  );

  load_align align0 (
    .word   (word),
    .offset (offset),
    .op     (op),
    .rdata  (rdata)
  );

  assign rvalid = hit;  // cache hit or registered uncached word

  // stores go straight through, no buffering
  assign bus_araddr  = addr;
  assign bus_awaddr  = addr;
  assign bus_awvalid = wen;
  assign bus_wvalid  = wen;
  assign bus_wdata   = wdata;
  assign wready      = bus_wready;

endmodule

//--- hw/mem_map_pkg.sv
package mem_map_pkg;

  // platform regions, limits are exclusive
  parameter logic [31:0] clint_base    = 32'h0200_0048;
  parameter logic [31:0] clint_limit   = 32'h0200_0050;
  parameter logic [31:0] sram_base     = 32'h0f00_0000;
  parameter logic [31:0] sram_limit    = 32'h0f00_2000;
  parameter logic [31:0] uart_base     = 32'h1000_0000;
  parameter logic [31:0] uart_limit    = 32'h1002_0000;
  parameter logic [31:0] flash_base    = 32'h3000_0000;
  parameter logic [31:0] flash_limit   = 32'h4000_0000;
  parameter logic [31:0] psram_base    = 32'h8000_0000;
  parameter logic [31:0] psram_limit   = 32'h8040_0000;
  parameter logic [31:0] sdram_base    = 32'ha000_0000;
  parameter logic [31:0] sdram_limit   = 32'hd000_0000;

  // not mapped for the lsu, only listed as uncacheable
  parameter logic [31:0] plic_base     = 32'h0c00_0000;
  parameter logic [31:0] plic_limit    = 32'h0d00_0000;

  // i/o window at the bottom of sdram
  parameter logic [31:0] sdram_io_base  = 32'ha000_0000;
  parameter logic [31:0] sdram_io_limit = 32'hb000_0000;

  function automatic logic in_region(
    input logic [31:0] a,
    input logic [31:0] base,
    input logic [31:0] limit
  );
    return (a >= base) && (a < limit);
  endfunction

endpackage

//--- sources.f
hw/lsu_pkg.sv
hw/mem_map_pkg.sv
hw/lsu_request_decode.sv
hw/l1d_cache.sv
hw/load_align.sv
hw/lsu_top.sv
test/tb_clock_gen.sv
test/tb_lsu.sv

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

//--- test/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  localparam int idx_bits   = 4;
  localparam int lines      = 2 ** idx_bits;
  localparam int max_cycles = 200 * 20;  // ~200 requests, ~20 cycles each

  logic clock, reset;
  logic [31:0] addr, wdata, rdata;
  lsu_pkg::lsu_op_t op;
  logic ren, wen, fence, rvalid, wready;
  logic [31:0] bus_araddr, bus_awaddr, bus_wdata, bus_rdata;
  logic bus_arvalid, bus_awvalid, bus_wvalid, bus_rvalid, bus_wready;
  logic [7:0] bus_rstrb, bus_wstrb;

  integer seed = 32'h3b3e_0d8c;
  logic [31:0] mem [logic [29:0]];  // sparse backing store, by word address

  // shadow of the cache state
  logic        sh_valid [lines];
  logic [31:0] sh_tag   [lines];
  logic [31:0] sh_data  [lines];

  logic [31:0] exp_rdata, exp_addr, exp_wdata;
  logic [7:0]  exp_strb;
  logic exp_hit, exp_uc, load_done, store_done, saw_ar, rv_prev;
  logic ar_s, rv_s, wv_s, wr_s;
  logic [31:0] ra_s, wa_s, wd_s, wword;
  logic [7:0] ws_s;
  int req_cycles, rd_wait, wr_wait, cycles, error_count;

  tb_clock_gen clk0 (.clock(clock), .reset(reset));

  lsu_top #(.l1d_index_bits(idx_bits)) dut0 (
    .clock(clock), .reset(reset), .addr(addr), .op(op), .ren(ren), .wen(wen),
    .wdata(wdata), .fence(fence), .rdata(rdata), .rvalid(rvalid), .wready(wready),
    .bus_araddr(bus_araddr), .bus_arvalid(bus_arvalid), .bus_rstrb(bus_rstrb),
    .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid), .bus_awaddr(bus_awaddr),
    .bus_awvalid(bus_awvalid), .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb),
    .bus_wvalid(bus_wvalid), .bus_wready(bus_wready)
  );

  function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    if (mem.exists(a[31:2])) return mem[a[31:2]];
    return wa ^ {wa[15:0], wa[31:16]} ^ 32'h6c1d_47e3;  // untouched words
  endfunction

  function automatic logic is_uncacheable(input logic [31:0] a);
    return (a >= mem_map_pkg::clint_base && a < mem_map_pkg::clint_limit) ||
           (a >= mem_map_pkg::plic_base && a < mem_map_pkg::plic_limit) ||
           (a >= mem_map_pkg::uart_base && a < mem_map_pkg::uart_limit) ||
           (a >= mem_map_pkg::sdram_io_base && a < mem_map_pkg::sdram_io_limit);
  endfunction

  function automatic logic [7:0] size_strobe(input lsu_pkg::lsu_op_t o);
    case (o)
      lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return 8'h01;
      lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 8'h03;
      default: return 8'h0f;
    endcase
  endfunction

  // expected load result from op, address and memory word
  function automatic logic [31:0] ref_load(input lsu_pkg::lsu_op_t o,
                                           input logic [31:0] a, input logic [31:0] w);
    logic [31:0] s;
    s = w >> (8 * a[1:0]);
    case (o)
      lsu_pkg::op_lb:  return {{24{s[7]}}, s[7:0]};
      lsu_pkg::op_lbu: return {24'h0, s[7:0]};
      lsu_pkg::op_lh:  return {{16{s[15]}}, s[15:0]};
      lsu_pkg::op_lhu: return {16'h0, s[15:0]};
      default:         return s;
    endcase
  endfunction

  task automatic stop_run();
    error_count++;
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_fail(input string msg);
    $display("Error: %s", msg);
    stop_run();
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    stop_run();
  endtask

  // bus memory model, answers after 1 to 3 cycles
  always @(posedge clock) begin
    ar_s = bus_arvalid;
    rv_s = bus_rvalid;
    ra_s = bus_araddr;
    wv_s = bus_wvalid;
    wr_s = bus_wready;
    wa_s = bus_awaddr;
    wd_s = bus_wdata;
    ws_s = bus_wstrb;
    #1;
    bus_rvalid = 1'b0;
    bus_wready = 1'b0;
    if (reset) begin
      rd_wait = 0;
      wr_wait = 0;
    end else begin
      if (rd_wait > 0) begin
        rd_wait--;
        if (rd_wait == 0) begin
          bus_rvalid = 1'b1;
          bus_rdata  = mem_word(ra_s);
        end
      end else if (ar_s && !rv_s) begin
        rd_wait = 1 + rnd(3);
      end
      if (wr_wait > 0) begin
        wr_wait--;
        if (wr_wait == 0) begin
          bus_wready = 1'b1;
          wword = mem_word(wa_s);
          for (int b = 0; b < 4; b++) begin
            if (ws_s[b]) wword[8*b +: 8] = wd_s[8*b +: 8];  // data is unshifted
          end
          mem[wa_s[31:2]] = wword;
        end
      end else if (wv_s && !wr_s) begin
        wr_wait = 1 + rnd(3);
      end
    end
  end

  // compare process
  always @(posedge clock) begin
    if (reset) begin
      cycles     = 0;
      req_cycles = 0;
      saw_ar     = 1'b0;
      rv_prev    = 1'b0;
    end else begin
      cycles++;
      if (cycles >= max_cycles) report_fail("timeout, the run did not finish in time");
      assert (bus_awvalid === wen && bus_wvalid === wen)
        else report_fail("bus write valids do not follow wen");
      assert (wready === bus_wready)
        else report_fail("wready does not follow bus_wready");
      if (!ren) begin
        assert (!rvalid && !bus_arvalid)
          else report_fail("rvalid or bus_arvalid high with no load pending");
      end else begin
        req_cycles++;
        if (bus_arvalid) saw_ar = 1'b1;
        if (rvalid) begin
          assert (rdata === exp_rdata) else fail_value("rdata", rdata, exp_rdata);
          assert (bus_rstrb === exp_strb) else fail_value("bus_rstrb", bus_rstrb, exp_strb);
          if (exp_hit) begin
            assert (!saw_ar && req_cycles == 1)
              else report_fail("load to a cached line was not served at once");
          end else begin
            assert (saw_ar) else report_fail("cache miss completed without a bus read");
            assert (rv_prev) else report_fail("load rvalid not one cycle after bus_rvalid");
          end
          req_cycles = 0;
          saw_ar     = 1'b0;
          load_done  = 1'b1;
        end
      end
      if (wen && wready) begin
        assert (bus_wstrb === exp_strb) else fail_value("bus_wstrb", bus_wstrb, exp_strb);
        assert (bus_wdata === exp_wdata) else fail_value("bus_wdata", bus_wdata, exp_wdata);
        assert (bus_awaddr === exp_addr) else fail_value("bus_awaddr", bus_awaddr, exp_addr);
        store_done = 1'b1;
      end
      rv_prev = bus_rvalid;
    end
  end

  task automatic load_and_check(input lsu_pkg::lsu_op_t o, input logic [31:0] a);
    int idx;
    logic [31:0] w;
    idx = (a >> 2) % lines;
    exp_uc  = is_uncacheable(a);
    exp_hit = !exp_uc && sh_valid[idx] && sh_tag[idx] == (a >> (idx_bits + 2));
    w = exp_hit ? sh_data[idx] : mem_word(a);
    exp_rdata = ref_load(o, a, w);
    exp_strb  = size_strobe(o);
    addr = a;
    op = o;
    load_done = 1'b0;
    ren = 1'b1;
    while (!load_done) begin
      @(posedge clock);
      #1;
    end
    ren = 1'b0;
    if (!exp_uc && !exp_hit) begin  // line filled on the miss
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = a >> (idx_bits + 2);
      sh_data[idx]  = w;
    end
  endtask

  task automatic store_and_check(input lsu_pkg::lsu_op_t o, input logic [31:0] a,
                                 input logic [31:0] d);
    int idx;
    idx = (a >> 2) % lines;
    exp_addr  = a;
    exp_wdata = d;
    exp_strb  = size_strobe(o);
    addr = a;
    op = o;
    wdata = d;
    store_done = 1'b0;
    wen = 1'b1;
    while (!store_done) begin
      @(posedge clock);
      #1;
    end
    wen = 1'b0;
    if (sh_valid[idx] && sh_tag[idx] == (a >> (idx_bits + 2))) sh_valid[idx] = 1'b0;
  endtask

  task automatic fence_cache();
    fence = 1'b1;
    @(posedge clock);
    #1 fence = 1'b0;
    for (int i = 0; i < lines; i++) sh_valid[i] = 1'b0;
  endtask

  task automatic random_access();
    lsu_pkg::lsu_op_t o;
    logic [31:0] a;
    a = (rnd(2) == 0) ? mem_map_pkg::sram_base : mem_map_pkg::psram_base;
    a = a + rnd(32) * 4;
    if (rnd(5) == 0) begin
      o = lsu_pkg::lsu_op_t'(4'h8 + rnd(3));
      store_and_check(o, a, $random(seed));
    end else begin
      o = lsu_pkg::lsu_op_t'(rnd(5));
      if (o == lsu_pkg::op_lb || o == lsu_pkg::op_lbu) a = a + rnd(4);
      else if (o != lsu_pkg::op_lw) a = a + 2 * rnd(2);  // halfword aligned
      load_and_check(o, a);
    end
  endtask

  initial begin
    logic [31:0] a;
    addr = '0;
    op = lsu_pkg::op_lw;
    ren = 1'b0;
    wen = 1'b0;
    wdata = '0;
    fence = 1'b0;
    bus_rdata = '0;
    bus_rvalid = 1'b0;
    bus_wready = 1'b0;
    error_count = 0;
    for (int i = 0; i < lines; i++) sh_valid[i] = 1'b0;
    wait (!reset);
    repeat (3) @(posedge clock);
    #1;
    for (int i = 0; i < lines; i++) begin
      load_and_check(lsu_pkg::op_lw, mem_map_pkg::sram_base + i * 4);
    end
    // uncached loads, memory changes between them
    for (int i = 0; i < 8; i++) begin
      a = mem_map_pkg::uart_base + rnd(64) * 4;
      mem[a[31:2]] = $random(seed);
      load_and_check(lsu_pkg::op_lw, a);
      a = mem_map_pkg::clint_base + rnd(2) * 4;
      mem[a[31:2]] = $random(seed);
      load_and_check(lsu_pkg::op_lbu, a + rnd(4));
    end
    // miss, then hit on stale data
    a = mem_map_pkg::sram_base + 32'h100;
    load_and_check(lsu_pkg::op_lw, a);
    mem[a[31:2]] = $random(seed);
    load_and_check(lsu_pkg::op_lw, a);
    store_and_check(lsu_pkg::op_sw, a, $random(seed));
    load_and_check(lsu_pkg::op_lw, a);
    store_and_check(lsu_pkg::op_sh, a, $random(seed));
    load_and_check(lsu_pkg::op_lhu, a);
    store_and_check(lsu_pkg::op_sb, a, $random(seed));
    load_and_check(lsu_pkg::op_lb, a);
    // fence drops every line
    for (int i = 0; i < 8; i++) begin
      load_and_check(lsu_pkg::op_lw, mem_map_pkg::psram_base + i * 4);
    end
    fence_cache();
    for (int i = 0; i < 8; i++) begin
      load_and_check(lsu_pkg::op_lw, mem_map_pkg::psram_base + i * 4);
    end
    for (int i = 0; i < 120; i++) random_access();
    repeat (2) @(posedge clock);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
